// File: source/game_cfg.svh
// Game configuration constants
// Raster size, lives, damaged window length, box sizes and colours
// shared by the player-status RTL and its testbench

`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Reduced raster, no blanking
`define GAME_H_TOTAL 64
`define GAME_V_TOTAL 48
`define GAME_COORD_W 7

// Lives counter
`define GAME_LIVES 3
`define GAME_LIVES_W 2

// Damaged window in frames
`define GAME_DAMAGED_FRAMES 20
`define GAME_DAMAGED_W 5

// Box sizes in pixels
`define GAME_PLAYER_W 8
`define GAME_PLAYER_H 6
`define GAME_MISSILE_W 2
`define GAME_MISSILE_H 4

// 8-bit RGB332 colours
`define GAME_COLOR_PLAYER 8'h1C
`define GAME_COLOR_MISSILE 8'hE0
`define GAME_COLOR_BG 8'h00

`endif

// File: source/game_pkg.sv
// Game types package
// Coordinate, scan position, box, drawer output and pixel structs
// passed between the player-status blocks

`default_nettype none

`include "game_cfg.svh"

package game_pkg;

    // One raster coordinate
    typedef logic [`GAME_COORD_W-1:0] coord_t;

    // Scan position with frame marker
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   frame_start;
    } scan_t;

    // Top-left corner of a box
    typedef struct packed {
        coord_t x;
        coord_t y;
    } box_t;

    // Drawer output, scan delayed by one cycle plus coverage flag
    typedef struct packed {
        scan_t scan;
        logic  hit;
    } draw_t;

    // Output pixel
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [7:0] color;
    } pixel_t;

endpackage

`default_nettype wire

// File: source/frame_scanner.sv
// Frame scanner
// Sweeps x across each line and y down the frame
// and marks the frame origin with a one-cycle strobe

`timescale 1ns/100ps
`default_nettype none

`include "game_cfg.svh"

module frame_scanner (
    input  logic             clk,
    input  logic             resetN,
    output game_pkg::scan_t  scan
);

    localparam int COORD_W = `GAME_COORD_W;
    localparam game_pkg::coord_t X_LAST = COORD_W'(`GAME_H_TOTAL - 1);
    localparam game_pkg::coord_t Y_LAST = COORD_W'(`GAME_V_TOTAL - 1);

    game_pkg::coord_t x_cnt;
    game_pkg::coord_t y_cnt;

    // Raster counters, x fastest
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == X_LAST) begin
            x_cnt <= '0;
            // End of line, step to next line or wrap the frame
            if (y_cnt == Y_LAST) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + COORD_W'(1);
            end
        end else begin
            x_cnt <= x_cnt + COORD_W'(1);
        end
    end

    // Scan output straight from the counters
    assign scan.x = x_cnt;
    assign scan.y = y_cnt;
    // Origin decode gives exactly one strobe per frame
    assign scan.frame_start = (x_cnt == '0) && (y_cnt == '0);

    // Line counter never leaves the visible width
    a_x_in_range: assert property (@(posedge clk) disable iff (!resetN)
        scan.x < `GAME_H_TOTAL);

endmodule

`default_nettype wire

// File: source/box_drawer.sv
// Box drawer
// Tests the scan position against a fixed-size box and registers
// the result together with the scan, one cycle of latency

`timescale 1ns/100ps
`default_nettype none

`include "game_cfg.svh"

module box_drawer #(
    parameter int BOX_W = 8,
    parameter int BOX_H = 8
) (
    input  logic             clk,
    input  logic             resetN,
    input  game_pkg::scan_t  scan,
    input  game_pkg::box_t   box,
    output game_pkg::draw_t  draw
);

    localparam int COORD_W = `GAME_COORD_W;

    // Exclusive box ends, one extra bit so a box at the edge cannot wrap
    logic [COORD_W:0] x_end;
    logic [COORD_W:0] y_end;
    logic             in_x;
    logic             in_y;

    assign x_end = {1'b0, box.x} + (COORD_W + 1)'(BOX_W);
    assign y_end = {1'b0, box.y} + (COORD_W + 1)'(BOX_H);

    // Inside when box corner <= position < box end
    assign in_x = (scan.x >= box.x) && ({1'b0, scan.x} < x_end);
    assign in_y = (scan.y >= box.y) && ({1'b0, scan.y} < y_end);

    // Register hit with the scan so both stay aligned downstream
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            draw <= '0;
        end else begin
            draw.scan <= scan;
            draw.hit  <= in_x && in_y;
        end
    end

endmodule

`default_nettype wire

// File: source/hit_detector.sv
// Hit detector
// Latches any player/missile overlap during a frame and reports it
// as a single collision strobe at the next aligned frame start

`timescale 1ns/100ps
`default_nettype none

module hit_detector (
    input  logic             clk,
    input  logic             resetN,
    input  game_pkg::draw_t  player_draw,
    input  game_pkg::draw_t  missile_draw,
    output logic             collision
);

    logic overlap_latch;
    logic both_hit;
    logic frame_start;

    // Both drawers cover the same pixel
    assign both_hit = player_draw.hit && missile_draw.hit;
    // Drawers share latency, either copy of the strobe will do
    assign frame_start = player_draw.scan.frame_start;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            overlap_latch <= 1'b0;
            collision     <= 1'b0;
        end else if (frame_start) begin
            // Report last frame, restart with the origin pixel
            collision     <= overlap_latch;
            overlap_latch <= both_hit;
        end else begin
            collision     <= 1'b0;
            overlap_latch <= overlap_latch || both_hit;
        end
    end

    // At most one strobe per frame
    a_single_pulse: assert property (@(posedge clk) disable iff (!resetN)
        collision |=> !collision);

endmodule

`default_nettype wire

// File: source/lives.sv
// Lives counter
// Takes a life on each accepted collision, holds a damaged window
// for a number of frames with player blinking, latches death

`timescale 1ns/100ps
`default_nettype none

`include "game_cfg.svh"

module lives #(
    parameter int LIVES_AMOUNT               = `GAME_LIVES,
    parameter int LIVES_AMOUNT_WIDTH         = `GAME_LIVES_W,
    parameter int DAMAGED_FRAME_AMOUNT       = `GAME_DAMAGED_FRAMES,
    parameter int DAMAGED_FRAME_AMOUNT_WIDTH = `GAME_DAMAGED_W
) (
    input  logic                          clk,
    input  logic                          resetN,
    input  logic                          start_of_frame,
    input  logic                          collision,
    output logic [LIVES_AMOUNT_WIDTH-1:0] remaining_lives,
    output logic                          player_faded,
    output logic                          player_damaged,
    output logic                          player_dead
);

    localparam logic [LIVES_AMOUNT_WIDTH-1:0] LIVES_INIT =
        LIVES_AMOUNT_WIDTH'(LIVES_AMOUNT);
    localparam logic [DAMAGED_FRAME_AMOUNT_WIDTH-1:0] TIMEOUT_INIT =
        DAMAGED_FRAME_AMOUNT_WIDTH'(DAMAGED_FRAME_AMOUNT);

    // Frames left in the damaged window
    logic [DAMAGED_FRAME_AMOUNT_WIDTH-1:0] damaged_timeout;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            remaining_lives <= LIVES_INIT;
            damaged_timeout <= '0;
            player_faded    <= 1'b0;
            player_damaged  <= 1'b0;
            player_dead     <= 1'b0;
        end else begin
            // Window over, show the player normally again
            if (damaged_timeout == '0) begin
                player_faded   <= 1'b0;
                player_damaged <= 1'b0;
            end else if (start_of_frame) begin
                damaged_timeout <= damaged_timeout - DAMAGED_FRAME_AMOUNT_WIDTH'(1);
                // Blink on the old count, low nibble at 8
                if (damaged_timeout[3:0] == 4'd8) begin
                    player_faded <= ~player_faded;
                end
            end

            // Later assignments override the window handling above
            if (remaining_lives == '0) begin
                // Dead player stays faded and damaged until reset
                player_dead    <= 1'b1;
                player_faded   <= 1'b1;
                player_damaged <= 1'b1;
            end else if (collision && (damaged_timeout == '0)) begin
                // Accepted hit, lose a life and open the window
                remaining_lives <= remaining_lives - LIVES_AMOUNT_WIDTH'(1);
                damaged_timeout <= TIMEOUT_INIT;
                player_faded    <= 1'b1;
                player_damaged  <= 1'b1;
            end
        end
    end

    // Lives only go down
    a_lives_monotonic: assert property (@(posedge clk) disable iff (!resetN)
        remaining_lives <= $past(remaining_lives));

    // Death only with no lives left
    a_dead_no_lives: assert property (@(posedge clk) disable iff (!resetN)
        player_dead |-> (remaining_lives == '0));

endmodule

`default_nettype wire

// File: source/pixel_mixer.sv
// Pixel mixer
// Picks the output colour by priority, player over missile over
// background, and hides the player while it blinks faded

`timescale 1ns/100ps
`default_nettype none

`include "game_cfg.svh"

module pixel_mixer (
    input  logic             clk,
    input  logic             resetN,
    input  game_pkg::draw_t  player_draw,
    input  game_pkg::draw_t  missile_draw,
    input  logic             player_faded,
    output game_pkg::pixel_t pixel
);

    logic [7:0] color;
    logic       player_visible;

    // Faded player lets whatever lies beneath show through
    assign player_visible = player_draw.hit && !player_faded;

    always_comb begin
        if (player_visible) begin
            color = `GAME_COLOR_PLAYER;
        end else if (missile_draw.hit) begin
            color = `GAME_COLOR_MISSILE;
        end else begin
            color = `GAME_COLOR_BG;
        end
    end

    // Pixel leaves two cycles after its scan position
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixel.x     <= '0;
            pixel.y     <= '0;
            pixel.color <= `GAME_COLOR_BG;
        end else begin
            pixel.x     <= player_draw.scan.x;
            pixel.y     <= player_draw.scan.y;
            pixel.color <= color;
        end
    end

endmodule

`default_nettype wire

// File: source/player_status_top.sv
// Player status top level
// Scanner feeds a player and a missile box drawer; overlap drives
// the hit detector and lives block, drawers and fade drive the mixer

`timescale 1ns/100ps
`default_nettype none

`include "game_cfg.svh"

module player_status_top (
    input  logic                     clk,
    input  logic                     resetN,
    input  game_pkg::box_t           player_box,
    input  game_pkg::box_t           missile_box,
    output game_pkg::pixel_t         pixel,
    output logic [`GAME_LIVES_W-1:0] remaining_lives,
    output logic                     player_faded,
    output logic                     player_damaged,
    output logic                     player_dead,
    output logic                     frame_start
);

    game_pkg::scan_t scan;
    game_pkg::draw_t player_draw;
    game_pkg::draw_t missile_draw;
    logic            collision;

    frame_scanner u_scanner (
        .clk    (clk),
        .resetN (resetN),
        .scan   (scan)
    );

    // Raw strobe, ahead of the drawer outputs
    assign frame_start = scan.frame_start;

    box_drawer #(
        .BOX_W (`GAME_PLAYER_W),
        .BOX_H (`GAME_PLAYER_H)
    ) u_player_drawer (
        .clk    (clk),
        .resetN (resetN),
        .scan   (scan),
        .box    (player_box),
        .draw   (player_draw)
    );

    box_drawer #(
        .BOX_W (`GAME_MISSILE_W),
        .BOX_H (`GAME_MISSILE_H)
    ) u_missile_drawer (
        .clk    (clk),
        .resetN (resetN),
        .scan   (scan),
        .box    (missile_box),
        .draw   (missile_draw)
    );

    hit_detector u_hits (
        .clk          (clk),
        .resetN       (resetN),
        .player_draw  (player_draw),
        .missile_draw (missile_draw),
        .collision    (collision)
    );

    // Timeout counts on the raw scanner strobe
    lives #(
        .LIVES_AMOUNT               (`GAME_LIVES),
        .LIVES_AMOUNT_WIDTH         (`GAME_LIVES_W),
        .DAMAGED_FRAME_AMOUNT       (`GAME_DAMAGED_FRAMES),
        .DAMAGED_FRAME_AMOUNT_WIDTH (`GAME_DAMAGED_W)
    ) u_lives (
        .clk             (clk),
        .resetN          (resetN),
        .start_of_frame  (scan.frame_start),
        .collision       (collision),
        .remaining_lives (remaining_lives),
        .player_faded    (player_faded),
        .player_damaged  (player_damaged),
        .player_dead     (player_dead)
    );

    pixel_mixer u_mixer (
        .clk          (clk),
        .resetN       (resetN),
        .player_draw  (player_draw),
        .missile_draw (missile_draw),
        .player_faded (player_faded),
        .pixel        (pixel)
    );

endmodule

`default_nettype wire

// File: bench/tb_tests.svh
// Directed tests for the player-status subsystem
// Each drives box positions, steps through frames and checks outputs

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// Walks one full frame of output pixels against the box geometry
task automatic check_frame_pixels(input int px, input int py, input int mx, input int my,
                                  input bit faded);
    int i;
    int x;
    int y;
    int expected;
    int bad;
    bit in_player;
    bit in_missile;
    bad = 0;
    // Origin pixel leaves the mixer two cycles after the scan
    repeat (2) @(negedge clk);
    for (i = 0; (i < FRAME_CYCLES) && (bad < 4); i++) begin
        x = i % `GAME_H_TOTAL;
        y = i / `GAME_H_TOTAL;
        in_player = (x >= px) && (x < px + `GAME_PLAYER_W) &&
                    (y >= py) && (y < py + `GAME_PLAYER_H);
        in_missile = (x >= mx) && (x < mx + `GAME_MISSILE_W) &&
                     (y >= my) && (y < my + `GAME_MISSILE_H);
        if (in_player && !faded) begin
            expected = int'(`GAME_COLOR_PLAYER);
        end else if (in_missile) begin
            expected = int'(`GAME_COLOR_MISSILE);
        end else begin
            expected = int'(`GAME_COLOR_BG);
        end
        if ((int'(pixel.color) != expected) || (int'(pixel.x) != x) || (int'(pixel.y) != y)) begin
            bad++;
            check_value($sformatf("pixel x at step %0d", i), x, int'(pixel.x));
            check_value($sformatf("pixel y at step %0d", i), y, int'(pixel.y));
            check_value($sformatf("color at %0d,%0d", x, y), expected, int'(pixel.color));
        end
        @(negedge clk);
    end
endtask

task automatic test_reset_state();
    int cycles;
    start_test("reset_state");
    check_value("lives", `GAME_LIVES, int'(remaining_lives));
    check_value("damaged", 0, int'(player_damaged));
    check_value("faded", 0, int'(player_faded));
    check_value("dead", 0, int'(player_dead));
    check_value("first frame_start", 1, int'(frame_start));
    // Strobe must be one cycle wide and recur once per raster
    wait_frames(1);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!frame_start && (cycles <= FRAME_CYCLES));
    check_value("frame period", FRAME_CYCLES, cycles);
    end_test();
endtask

task automatic test_no_overlap();
    int frame;
    start_test("no_overlap");
    // Player left of column 32, missile right of column 39
    place_boxes(rand_range(0, 24), rand_range(0, `GAME_V_TOTAL - `GAME_PLAYER_H),
                rand_range(40, `GAME_H_TOTAL - `GAME_MISSILE_W),
                rand_range(0, `GAME_V_TOTAL - `GAME_MISSILE_H));
    for (frame = 0; frame < 5; frame++) begin
        wait_frames(1);
        check_value("lives", `GAME_LIVES, int'(remaining_lives));
        check_value("damaged", 0, int'(player_damaged));
    end
    place_boxes(4, 4, 50, 40);
    end_test();
endtask

task automatic test_single_hit();
    int frames;
    start_test("single_hit");
    hit_once();
    wait_frames(1);
    check_value("lives after hit", `GAME_LIVES - 1, int'(remaining_lives));
    check_value("damaged after hit", 1, int'(player_damaged));
    // Overlap inside the window, timeout still running
    hit_once();
    wait_window_end(frames);
    frames = frames + 2;
    check_value("lives after second overlap", `GAME_LIVES - 1, int'(remaining_lives));
    if ((frames < `GAME_DAMAGED_FRAMES - 1) || (frames > `GAME_DAMAGED_FRAMES + 1)) begin
        check_value("damaged window frames", `GAME_DAMAGED_FRAMES, frames);
    end
    end_test();
endtask

task automatic test_fade_blink();
    int timeout;
    int frame;
    bit faded;
    start_test("fade_blink");
    hit_once();
    wait_frames(1);
    // Model state as seen at this frame start
    timeout = `GAME_DAMAGED_FRAMES;
    faded = 1'b1;
    for (frame = 0; frame < `GAME_DAMAGED_FRAMES + 2; frame++) begin
        check_value($sformatf("faded in frame %0d", frame), int'(faded), int'(player_faded));
        check_value($sformatf("damaged in frame %0d", frame), int'(timeout != 0),
                    int'(player_damaged));
        // Decrement at this frame start, blink on old nibble 8
        if (timeout != 0) begin
            if ((timeout % 16) == 8) begin
                faded = !faded;
            end
            timeout--;
        end
        if (timeout == 0) begin
            faded = 1'b0;
        end
        wait_frames(1);
    end
    end_test();
endtask

task automatic test_pixel_priority();
    start_test("pixel_priority");
    apply_reset();
    wait_frames(1);
    // Overlap covers columns 26 and 27, row 26 is missile only
    place_boxes(20, 20, 26, 23);
    check_frame_pixels(20, 20, 26, 23, 1'b0);
    wait_frames(1);
    check_value("faded after overlap", 1, int'(player_faded));
    check_frame_pixels(20, 20, 26, 23, 1'b1);
    place_boxes(4, 4, 50, 40);
    end_test();
endtask

task automatic test_death();
    int n;
    int frames;
    start_test("death");
    apply_reset();
    for (n = 1; n <= `GAME_LIVES; n++) begin
        hit_once();
        wait_frames(1);
        check_value($sformatf("lives after hit %0d", n), `GAME_LIVES - n,
                    int'(remaining_lives));
        if (n < `GAME_LIVES) begin
            wait_window_end(frames);
        end
    end
    // Flags must outlast the last damaged window
    for (n = 0; n < `GAME_DAMAGED_FRAMES + 4; n++) begin
        check_value("dead", 1, int'(player_dead));
        check_value("damaged", 1, int'(player_damaged));
        check_value("faded", 1, int'(player_faded));
        check_value("lives", 0, int'(remaining_lives));
        wait_frames(1);
    end
    end_test();
endtask

`endif

// File: bench/tb_player_status.sv
// Player status testbench
// Clock, reset and DUT with shared check, wait and report helpers
// around the directed tests in tb_tests.svh

`timescale 1ns/100ps
`default_nettype none

`include "game_cfg.svh"

module tb_player_status;

    localparam int FRAME_CYCLES = `GAME_H_TOTAL * `GAME_V_TOTAL;
    localparam int RESET_CYCLES = 10;

    logic                     clk = 1'b0;
    logic                     resetN;
    game_pkg::box_t           player_box;
    game_pkg::box_t           missile_box;
    game_pkg::pixel_t         pixel;
    logic [`GAME_LIVES_W-1:0] remaining_lives;
    logic                     player_faded;
    logic                     player_damaged;
    logic                     player_dead;
    logic                     frame_start;

    int    seed = 76;
    string test_name = "setup";
    int    error_count = 0;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    // 40 ns period
    always #20 clk = ~clk;

    player_status_top u_dut (
        .clk             (clk),
        .resetN          (resetN),
        .player_box      (player_box),
        .missile_box     (missile_box),
        .pixel           (pixel),
        .remaining_lives (remaining_lives),
        .player_faded    (player_faded),
        .player_damaged  (player_damaged),
        .player_dead     (player_dead),
        .frame_start     (frame_start)
    );

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            $display("error %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if ((error_count == 0) && (tests_failed == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Stuck DUT, stop the run with a reason
    task automatic abort_run(input string reason);
        error_count++;
        tests_run++;
        tests_failed++;
        $display("timeout in %s: %s", test_name, reason);
        finish_run();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", test_name, error_count - errors_at_start);
        end
    endtask

    // Reset held for a fixed number of cycles, released on a falling edge
    task automatic apply_reset();
        resetN = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        resetN = 1'b1;
    endtask

    task automatic place_boxes(input int px, input int py, input int mx, input int my);
        player_box.x  = game_pkg::coord_t'(px);
        player_box.y  = game_pkg::coord_t'(py);
        missile_box.x = game_pkg::coord_t'(mx);
        missile_box.y = game_pkg::coord_t'(my);
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Returns on the falling edge where the count-th frame start is seen
    task automatic wait_frames(input int count);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while ((seen < count) && (cycles < count * FRAME_CYCLES + 8)) begin
            @(negedge clk);
            cycles++;
            if (frame_start) begin
                seen++;
            end
        end
        if (seen < count) begin
            abort_run("frame start did not arrive in time");
        end
    endtask

    // Frame steps until damaged drops, sampled at frame starts
    task automatic wait_window_end(output int frames);
        frames = 0;
        while (player_damaged && (frames < `GAME_DAMAGED_FRAMES + 4)) begin
            wait_frames(1);
            frames++;
        end
        if (player_damaged) begin
            abort_run("damaged window did not close");
        end
    endtask

    // One frame of overlap away from the origin, then boxes apart again
    task automatic hit_once();
        wait_frames(1);
        place_boxes(20, 20, 24, 22);
        wait_frames(1);
        place_boxes(4, 4, 50, 40);
    endtask

    `include "tb_tests.svh"

    initial begin
        resetN = 1'b0;
        place_boxes(4, 4, 50, 40);
        apply_reset();
        test_reset_state();
        test_no_overlap();
        test_single_hit();
        test_fade_blink();
        test_pixel_priority();
        test_death();
        finish_run();
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
+incdir+bench
source/game_pkg.sv
source/frame_scanner.sv
source/box_drawer.sv
source/hit_detector.sv
source/lives.sv
source/pixel_mixer.sv
source/player_status_top.sv
bench/tb_player_status.sv

// File: Makefile
# Verilator build and run for the player-status testbench

VERILATOR ?= verilator
TOP       ?= tb_player_status
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  := All tests passed!
FAIL_MSG  := Test failures found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failures"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
